// File: common/mips_mem_pkg.sv
package mips_mem_pkg;

    // Data bus and byte address
    typedef logic [31:0] word_t;

    // One enable per byte lane, bit k selects data[8k+7:8k]
    typedef logic [3:0] byte_en_t;

    // Primary opcode field, instr[31:26]
    typedef logic [5:0] opcode_t;

    // Loads
    localparam opcode_t OP_LB  = 6'b100000;
    localparam opcode_t OP_LH  = 6'b100001;
    localparam opcode_t OP_LWL = 6'b100010;
    localparam opcode_t OP_LW  = 6'b100011;
    localparam opcode_t OP_LBU = 6'b100100;
    localparam opcode_t OP_LHU = 6'b100101;
    localparam opcode_t OP_LWR = 6'b100110;

    // Stores
    localparam opcode_t OP_SB  = 6'b101000;
    localparam opcode_t OP_SH  = 6'b101001;
    localparam opcode_t OP_SW  = 6'b101011;

    // Full word of ones, used for lane masks
    localparam word_t WORD_ONES = 32'hffff_ffff;

    // Lane with the lowest set enable, zero if none set
    function automatic logic [1:0] low_lane(input byte_en_t be);
        logic [1:0] lane;
        lane = 2'd0;
        for (int k = 3; k >= 0; k--) begin
            if (be[k]) lane = 2'(k);
        end
        return lane;
    endfunction

    // Lane with the highest set enable, zero if none set
    function automatic logic [1:0] high_lane(input byte_en_t be);
        logic [1:0] lane;
        lane = 2'd0;
        for (int k = 0; k < 4; k++) begin
            if (be[k]) lane = 2'(k);
        end
        return lane;
    endfunction

endpackage

// File: lsu/mips_lsu_issue.sv
`timescale 1ns/1ns

module mips_lsu_issue #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                      req,
    input  mips_mem_pkg::opcode_t     op,
    input  mips_mem_pkg::word_t       base,
    input  mips_mem_pkg::word_t       offset,
    input  mips_mem_pkg::word_t       rt,
    output logic                      ram_en,
    output logic                      ram_we,
    output logic [ADDR_WIDTH-1:0]     ram_addr,
    output mips_mem_pkg::byte_en_t    ram_be,
    output mips_mem_pkg::word_t       ram_wdata,
    output logic                      ld_issue,
    output logic                      addr_error
);

    mips_mem_pkg::word_t eff_addr;
    logic [1:0]          a;             // Byte offset within word
    logic                is_load;
    logic                is_store;
    logic                is_byte;
    logic                is_half;
    logic                is_word;
    logic                misaligned;
    logic                access;

    assign eff_addr = base + offset;
    assign a        = eff_addr[1:0];

    // Opcode decode
    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_byte  = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        case (op)
            mips_mem_pkg::OP_LB,
            mips_mem_pkg::OP_LBU: begin
                is_load = 1'b1;
                is_byte = 1'b1;
            end
            mips_mem_pkg::OP_LH,
            mips_mem_pkg::OP_LHU: begin
                is_load = 1'b1;
                is_half = 1'b1;
            end
            mips_mem_pkg::OP_LW: begin
                is_load = 1'b1;
                is_word = 1'b1;
            end
            mips_mem_pkg::OP_LWL,
            mips_mem_pkg::OP_LWR: is_load = 1'b1;   // Any alignment
            mips_mem_pkg::OP_SB: begin
                is_store = 1'b1;
                is_byte  = 1'b1;
            end
            mips_mem_pkg::OP_SH: begin
                is_store = 1'b1;
                is_half  = 1'b1;
            end
            mips_mem_pkg::OP_SW: begin
                is_store = 1'b1;
                is_word  = 1'b1;
            end
            default: ;                              // Not a memory op
        endcase
    end

    // Lane enables from low address bits
    always_comb begin
        case (op)
            mips_mem_pkg::OP_LWL: begin
                case (a)
                    2'd0:    ram_be = 4'b0001;
                    2'd1:    ram_be = 4'b0011;
                    2'd2:    ram_be = 4'b0111;
                    default: ram_be = 4'b1111;
                endcase
            end
            mips_mem_pkg::OP_LWR: ram_be = 4'b1111 << a;
            default: begin
                if (is_byte)      ram_be = 4'b0001 << a;
                else if (is_half) ram_be = 4'b0011 << a;
                else              ram_be = 4'b1111;
            end
        endcase
    end

    assign misaligned = (is_half && a[0]) || (is_word && (a != 2'd0));
    assign access     = req && (is_load || is_store);

    assign addr_error = access && misaligned;
    assign ram_en     = access && !misaligned;
    assign ram_we     = ram_en && is_store;
    assign ld_issue   = ram_en && is_load;
    assign ram_addr   = eff_addr[ADDR_WIDTH+1:2];
    assign ram_wdata  = rt << {a, 3'b000};  // Store data onto its lanes

endmodule

// File: lsu/mips_load_align.sv
`timescale 1ns/1ns

module mips_load_align (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ld_issue,
    input  mips_mem_pkg::opcode_t  op,
    input  mips_mem_pkg::word_t    rt,
    input  mips_mem_pkg::byte_en_t ram_be,
    input  mips_mem_pkg::word_t    ram_rdata,
    output logic                   load_valid,
    output mips_mem_pkg::word_t    load_data
);

    // Request attributes held across the RAM read cycle
    mips_mem_pkg::byte_en_t be_q;
    mips_mem_pkg::opcode_t  op_q;
    mips_mem_pkg::word_t    rt_q;

    logic [1:0]          lo_lane;
    logic [1:0]          hi_lane;
    logic [1:0]          lwl_shift;
    logic [7:0]          sel_byte;
    logic [15:0]         sel_half;
    mips_mem_pkg::word_t lwl_data;
    mips_mem_pkg::word_t lwl_mask;
    mips_mem_pkg::word_t lwr_data;
    mips_mem_pkg::word_t lwr_mask;
    mips_mem_pkg::word_t rd_down;

    always_ff @(posedge clk) begin
        if (reset) begin
            load_valid <= 1'b0;
            be_q       <= '0;
        end else begin
            load_valid <= ld_issue;
            if (ld_issue) begin
                be_q <= ram_be;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_issue) begin
            op_q <= op;
            rt_q <= rt;
        end
    end

    assign lo_lane   = mips_mem_pkg::low_lane(be_q);
    assign hi_lane   = mips_mem_pkg::high_lane(be_q);
    assign lwl_shift = 2'd3 - hi_lane;

    // Addressed lane moved down to bit 0
    assign rd_down  = ram_rdata >> {lo_lane, 3'b000};
    assign sel_byte = rd_down[7:0];
    assign sel_half = rd_down[15:0];

    // LWL: lanes 0..a go to the top of the result
    assign lwl_data = ram_rdata << {lwl_shift, 3'b000};
    assign lwl_mask = mips_mem_pkg::WORD_ONES << {lwl_shift, 3'b000};

    // LWR: lanes a..3 go to the bottom of the result
    assign lwr_data = rd_down;
    assign lwr_mask = mips_mem_pkg::WORD_ONES >> {lo_lane, 3'b000};

    always_comb begin
        case (op_q)
            mips_mem_pkg::OP_LB:
                load_data = {{24{sel_byte[7]}}, sel_byte};
            mips_mem_pkg::OP_LBU:
                load_data = {24'd0, sel_byte};
            mips_mem_pkg::OP_LH:
                load_data = {{16{sel_half[15]}}, sel_half};
            mips_mem_pkg::OP_LHU:
                load_data = {16'd0, sel_half};
            mips_mem_pkg::OP_LWL:
                load_data = (lwl_data & lwl_mask) | (rt_q & ~lwl_mask);
            mips_mem_pkg::OP_LWR:
                load_data = (lwr_data & lwr_mask) | (rt_q & ~lwr_mask);
            default:
                load_data = ram_rdata;      // LW
        endcase
    end

endmodule

// File: hdl/mips_data_ram.sv
`timescale 1ns/1ns

module mips_data_ram #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                   clk,
    input  logic                   ram_en,
    input  logic                   ram_we,
    input  logic [ADDR_WIDTH-1:0]  ram_addr,
    input  mips_mem_pkg::byte_en_t ram_be,
    input  mips_mem_pkg::word_t    ram_wdata,
    output mips_mem_pkg::word_t    ram_rdata
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    mips_mem_pkg::word_t mem [DEPTH];

    // Lane-wise write under the byte enables
    always_ff @(posedge clk) begin
        if (ram_en && ram_we) begin
            for (int k = 0; k < 4; k++) begin
                if (ram_be[k]) begin
                    mem[ram_addr][8*k +: 8] <= ram_wdata[8*k +: 8];
                end
            end
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (ram_en && !ram_we) begin
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

// File: hdl/mips_mem_stage.sv
`timescale 1ns/1ns

module mips_mem_stage #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  mips_mem_pkg::opcode_t op,
    input  mips_mem_pkg::word_t   base,
    input  mips_mem_pkg::word_t   offset,
    input  mips_mem_pkg::word_t   rt,
    output logic                  load_valid,
    output mips_mem_pkg::word_t   load_data,
    output logic                  addr_error
);

    logic                   ram_en;
    logic                   ram_we;
    logic [ADDR_WIDTH-1:0]  ram_addr;
    mips_mem_pkg::byte_en_t ram_be;
    mips_mem_pkg::word_t    ram_wdata;
    mips_mem_pkg::word_t    ram_rdata;
    logic                   ld_issue;

    mips_lsu_issue #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_issue (
        .req        (req),
        .op         (op),
        .base       (base),
        .offset     (offset),
        .rt         (rt),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_be     (ram_be),
        .ram_wdata  (ram_wdata),
        .ld_issue   (ld_issue),
        .addr_error (addr_error)
    );

    mips_data_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ram (
        .clk       (clk),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_be    (ram_be),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    mips_load_align u_align (
        .clk        (clk),
        .reset      (reset),
        .ld_issue   (ld_issue),
        .op         (op),
        .rt         (rt),
        .ram_be     (ram_be),
        .ram_rdata  (ram_rdata),
        .load_valid (load_valid),
        .load_data  (load_data)
    );

endmodule

// File: sim/mips_mem_stage_assert.sv
`timescale 1ns/1ns

module mips_mem_stage_assert (
    input logic clk,
    input logic reset,
    input logic ram_en,
    input logic ram_we,
    input logic addr_error,
    input logic ld_issue,
    input logic load_valid
);

    property write_is_access;
        @(posedge clk) disable iff (reset)
            ram_we |-> ram_en;
    endproperty

    property error_blocks_access;
        @(posedge clk) disable iff (reset)
            addr_error |-> !ram_en;
    endproperty

    // Result strobe exactly one cycle after the read
    property load_one_cycle;
        @(posedge clk) disable iff (reset)
            ld_issue |=> load_valid;
    endproperty

    a_write_is_access: assert property (write_is_access)
        else $error("ram_we high while ram_en is low");

    a_error_blocks_access: assert property (error_blocks_access)
        else $error("RAM access on a misaligned request");

    a_load_one_cycle: assert property (load_one_cycle)
        else $error("load_valid missing one cycle after ld_issue");

endmodule

// Issue and aligner strobes meet at the stage top
bind mips_mem_stage mips_mem_stage_assert u_assert (
    .clk        (clk),
    .reset      (reset),
    .ram_en     (ram_en),
    .ram_we     (ram_we),
    .addr_error (addr_error),
    .ld_issue   (ld_issue),
    .load_valid (load_valid)
);

// File: sim/mips_mem_stage_tb.sv
`timescale 1ns/1ns

module mips_mem_stage_tb;

    localparam int ADDR_WIDTH   = 8;
    localparam int FIELDS       = 6;            // Columns per pattern line
    localparam int MAX_PATTERNS = 80;
    localparam logic [31:0] END_MARK = 32'h0000_00ff;

    logic                  clk;
    logic                  reset;
    logic                  req;
    mips_mem_pkg::opcode_t op;
    mips_mem_pkg::word_t   base;
    mips_mem_pkg::word_t   offset;
    mips_mem_pkg::word_t   rt;
    logic                  load_valid;
    mips_mem_pkg::word_t   load_data;
    logic                  addr_error;

    logic [31:0] patterns [MAX_PATTERNS*FIELDS];
    int          n_patterns;
    int          cycle_count;
    int          cycle_limit;

    // Expectation for the request on the inputs
    logic                exp_error;
    logic                exp_valid;
    mips_mem_pkg::word_t exp_data;

    // Expectation for the load in flight
    logic                pend_valid;
    mips_mem_pkg::word_t pend_data;
    int                  pend_idx;

    mips_mem_stage #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_dut (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .op         (op),
        .base       (base),
        .offset     (offset),
        .rt         (rt),
        .load_valid (load_valid),
        .load_data  (load_data),
        .addr_error (addr_error)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    // Op 00 is an idle cycle with req low
    task automatic apply_pattern(input int idx);
        logic [31:0] op_field;
        op_field  = patterns[idx*FIELDS];
        req       = (op_field != 32'h0);
        op        = op_field[5:0];
        base      = patterns[idx*FIELDS+1];
        offset    = patterns[idx*FIELDS+2];
        rt        = patterns[idx*FIELDS+3];
        exp_data  = patterns[idx*FIELDS+4];
        exp_error = patterns[idx*FIELDS+5][1];
        exp_valid = patterns[idx*FIELDS+5][0];
    endtask

    task automatic check_request(input int idx);
        assert (addr_error === exp_error) else begin
            $display("[ERROR] %0t: pattern %0d addr_error %b, expected %b",
                     $time, idx, addr_error, exp_error);
            abort_run();
        end
    endtask

    task automatic check_result();
        assert (load_valid === pend_valid) else begin
            $display("[ERROR] %0t: pattern %0d load_valid %b, expected %b",
                     $time, pend_idx, load_valid, pend_valid);
            abort_run();
        end
        if (pend_valid) begin
            assert (load_data === pend_data) else begin
                $display("[ERROR] %0t: pattern %0d load_data %h, expected %h",
                         $time, pend_idx, load_data, pend_data);
                abort_run();
            end
        end
    endtask

    initial begin
        reset       = 1'b1;
        req         = 1'b0;
        op          = '0;
        base        = '0;
        offset      = '0;
        rt          = '0;
        exp_error   = 1'b0;
        exp_valid   = 1'b0;
        exp_data    = '0;
        pend_valid  = 1'b0;
        pend_data   = '0;
        pend_idx    = 0;
        cycle_count = 0;
        cycle_limit = MAX_PATTERNS + 50;

        $readmemh("sim/mem_patterns.hex", patterns);
        n_patterns = 0;
        while (n_patterns < MAX_PATTERNS && patterns[n_patterns*FIELDS] != END_MARK) begin
            n_patterns++;
        end
        assert (n_patterns > 0 && n_patterns < MAX_PATTERNS) else begin
            $display("Pattern file sim/mem_patterns.hex is missing, empty or has no end line");
            abort_run();
        end
        cycle_limit = n_patterns + 50;

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < n_patterns; i++) begin
            apply_pattern(i);
            @(posedge clk);
            check_request(i);
            pend_valid = exp_valid;         // Load result due next cycle
            pend_data  = exp_data;
            pend_idx   = i;
            @(negedge clk);
            check_result();
        end

        $display("sim passed");
        $finish;
    end

endmodule

// File: sim/mem_patterns.hex
// op base offset rt expected_load_data flags
// flags bit1 expected addr_error, bit0 expected load_valid; op 00 idle cycle, op ff end
2b 00000100 00000000 807fc312 00000000 0
2b 00000100 00000004 12345678 00000000 0
2b 00000100 00000008 deadbeef 00000000 0
2b 00000100 0000000c 0badf00d 00000000 0
23 00000100 00000000 00000000 807fc312 1
23 00000100 00000004 00000000 12345678 1
23 00000100 00000008 00000000 deadbeef 1
23 00000100 0000000c 00000000 0badf00d 1
00 00000000 00000000 00000000 00000000 0
28 00000100 0000000d ffffffa5 00000000 0
29 00000100 0000000e 12347e55 00000000 0
23 00000100 0000000c 00000000 7e55a50d 1
00 00000000 00000000 00000000 00000000 0
20 00000100 00000000 00000000 00000012 1
20 00000100 00000001 00000000 ffffffc3 1
20 00000100 00000002 00000000 0000007f 1
20 00000100 00000003 00000000 ffffff80 1
24 00000100 00000000 00000000 00000012 1
24 00000100 00000001 00000000 000000c3 1
24 00000104 fffffffe 00000000 0000007f 1
24 00000100 00000003 00000000 00000080 1
00 00000000 00000000 00000000 00000000 0
21 00000100 00000008 00000000 ffffbeef 1
21 00000100 0000000a 00000000 ffffdead 1
25 00000100 00000008 00000000 0000beef 1
25 00000100 0000000a 00000000 0000dead 1
21 00000100 00000004 00000000 00005678 1
25 00000100 00000006 00000000 00001234 1
00 00000000 00000000 00000000 00000000 0
22 00000100 00000004 aabbccdd 78bbccdd 1
22 00000100 00000005 aabbccdd 5678ccdd 1
22 00000100 00000006 aabbccdd 345678dd 1
22 00000100 00000007 aabbccdd 12345678 1
26 00000100 00000004 aabbccdd 12345678 1
26 00000100 00000005 aabbccdd aa123456 1
26 00000100 00000006 aabbccdd aabb1234 1
26 00000100 00000007 aabbccdd aabbcc12 1
00 00000000 00000000 00000000 00000000 0
21 00000100 00000001 00000000 00000000 2
25 00000100 00000003 00000000 00000000 2
23 00000100 00000002 00000000 00000000 2
23 00000100 00000009 00000000 00000000 2
2b 00000100 00000005 ffffffff 00000000 2
29 00000100 0000000b ffffffff 00000000 2
0f 00000100 00000000 ffffffff 00000000 0
23 00000100 00000004 00000000 12345678 1
23 00000100 00000008 00000000 deadbeef 1
00 00000000 00000000 00000000 00000000 0
2b 00000100 00000010 cafe0123 00000000 0
23 00000100 00000010 00000000 cafe0123 1
28 00000100 00000010 00000099 00000000 0
20 00000100 00000010 00000000 ffffff99 1
25 00000100 00000012 00000000 0000cafe 1
23 00000100 00000004 00000000 12345678 1
23 00000100 0000000c 00000000 7e55a50d 1
23 00000100 00000010 00000000 cafe0199 1
2b 00000100 00000010 00000000 00000000 0
23 00000100 00000010 00000000 00000000 1
ff 00000000 00000000 00000000 00000000 0

// File: mips_mem_stage.f
common/mips_mem_pkg.sv
lsu/mips_lsu_issue.sv
lsu/mips_load_align.sv
hdl/mips_data_ram.sv
hdl/mips_mem_stage.sv
sim/mips_mem_stage_assert.sv
sim/mips_mem_stage_tb.sv

// File: Makefile
TOP = mips_mem_stage_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the obj_dir build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f mips_mem_stage.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
